// ==== src/aes_pkg.sv ====
package aes_pkg;

localparam int blk_s = 128;
localparam int key_s = 128;
localparam int nr = 10;
localparam int rnd_w = 4;
localparam int cmd_w = 2;

// The fourth code is a no-op.
localparam logic [cmd_w-1:0] cmd_set_key = 2'd0;
localparam logic [cmd_w-1:0] cmd_encrypt = 2'd1;
localparam logic [cmd_w-1:0] cmd_decrypt = 2'd2;

function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] r;
        p = a;
        r = 8'h00;
        for (int i = 0; i < 8; i++) begin
                if (b[i])
                        r = r ^ p;
                p = xtime(p);
        end
        return r;
endfunction

// Inverse as a^254, so zero maps to zero.
function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] p;
        logic [7:0] r;
        p = a;
        r = 8'h01;
        for (int i = 0; i < 7; i++) begin
                p = gf_mul(p, p);
                r = gf_mul(r, p);
        end
        return r;
endfunction

function automatic logic [7:0] rotl(input logic [7:0] a, input int n);
        return (a << n) | (a >> (8 - n));
endfunction

function automatic logic [7:0] sbox(input logic [7:0] a);
        logic [7:0] b;
        b = gf_inv(a);
        return b ^ rotl(b, 1) ^ rotl(b, 2) ^ rotl(b, 3) ^ rotl(b, 4) ^ 8'h63;
endfunction

function automatic logic [7:0] inv_sbox(input logic [7:0] a);
        return gf_inv(rotl(a, 1) ^ rotl(a, 3) ^ rotl(a, 6) ^ 8'h05); // Undo affine first.
endfunction

function automatic logic [0:31] mix_col(input logic [0:31] w);
        logic [7:0] a0, a1, a2, a3;
        a0 = w[0:7];
        a1 = w[8:15];
        a2 = w[16:23];
        a3 = w[24:31];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
endfunction

// Preconditioned column fed through the forward mix.
function automatic logic [0:31] inv_mix_col(input logic [0:31] w);
        logic [7:0] u, v;
        u = xtime(xtime(w[0:7] ^ w[16:23]));
        v = xtime(xtime(w[8:15] ^ w[24:31]));
        return mix_col({w[0:7] ^ u, w[8:15] ^ v, w[16:23] ^ u, w[24:31] ^ v});
endfunction

endpackage

// ==== src/round_key.sv ====
`timescale 1ns/100ps

module round_key import aes_pkg::*; (
        input  logic             clk,
        input  logic             reset,
        input  logic             en,

        input  logic [0:key_s-1] key,

        output logic [0:key_s-1] round_key,
        output logic [rnd_w-1:0] round_no,
        output logic             w_e,

        output logic             en_o
);

logic [7:0]       rcon;
logic [0:31]      rot;
logic [0:31]      sub;
logic [0:key_s-1] next_key;

always_comb begin
        rot = {round_key[104:127], round_key[96:103]};          // RotWord of w3.
        sub = {sbox(rot[0:7]), sbox(rot[8:15]), sbox(rot[16:23]), sbox(rot[24:31])};
        sub = sub ^ {rcon, 24'h000000};
        next_key[0:31] = round_key[0:31] ^ sub;
        next_key[32:63] = round_key[32:63] ^ next_key[0:31];
        next_key[64:95] = round_key[64:95] ^ next_key[32:63];
        next_key[96:127] = round_key[96:127] ^ next_key[64:95];
end

// Write strobe stays high through round 10.
always_ff @(posedge clk) begin
        if (reset) begin
                w_e <= 1'b0;
                round_no <= '0;
                en_o <= 1'b0;
        end else begin
                en_o <= w_e && round_no == rnd_w'(nr);
                if (en) begin
                        w_e <= 1'b1;
                        round_no <= '0;
                end else if (w_e) begin
                        if (round_no == rnd_w'(nr))
                                w_e <= 1'b0;
                        else
                                round_no <= round_no + 1'b1;
                end
        end
end

always_ff @(posedge clk) begin
        if (en) begin
                round_key <= key;
                rcon <= 8'h01;
        end else if (w_e && round_no != rnd_w'(nr)) begin
                round_key <= next_key;
                rcon <= xtime(rcon);
        end
end

endmodule

// ==== src/block_ram.sv ====
`timescale 1ns/100ps

module block_ram #(
        parameter int addr_width = 4,
        parameter int data_width = 128
) (
        input  logic                  clk,

        input  logic [addr_width-1:0] addr,
        input  logic [0:data_width-1] i_data,
        input  logic                  w_e,

        output logic [0:data_width-1] o_data
);

logic [0:data_width-1] mem [0:2**addr_width-1];

// Read returns the old word on a write cycle.
always_ff @(posedge clk) begin
        if (w_e)
                mem[addr] <= i_data;
        o_data <= mem[addr];
end

endmodule

// ==== src/cipher.sv ====
`timescale 1ns/100ps

module cipher import aes_pkg::*; (
        input  logic             clk,
        input  logic             reset,
        input  logic             en,

        input  logic [0:blk_s-1] plaintext,
        input  logic [0:key_s-1] key,
        output logic [rnd_w-1:0] round_no,

        output logic [0:blk_s-1] ciphertext,
        output logic             en_o
);

logic             running;
logic [rnd_w-1:0] cnt;
logic [0:blk_s-1] state;
logic [0:blk_s-1] ss;
logic [0:blk_s-1] mixed;

// Byte 4c+r sits in row r, column c.
function automatic logic [0:blk_s-1] sub_shift(input logic [0:blk_s-1] s);
        logic [0:blk_s-1] t;
        for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                        t[8*(4*c+r) +: 8] = sbox(s[8*(4*((c+r)%4)+r) +: 8]);
                end
        end
        return t;
endfunction

function automatic logic [0:blk_s-1] mix_cols(input logic [0:blk_s-1] s);
        logic [0:blk_s-1] t;
        for (int c = 0; c < 4; c++) begin
                t[32*c +: 32] = mix_col(s[32*c +: 32]);
        end
        return t;
endfunction

assign ss = sub_shift(state);
assign mixed = mix_cols(ss);
assign round_no = (cnt > rnd_w'(nr)) ? rnd_w'(nr) : cnt;
assign ciphertext = state;

// Key for round cnt-1 is on the memory output.
always_ff @(posedge clk) begin
        if (reset) begin
                running <= 1'b0;
                cnt <= '0;
                en_o <= 1'b0;
        end else begin
                en_o <= running && cnt == rnd_w'(nr + 1);
                if (en) begin
                        running <= 1'b1;
                        cnt <= '0;
                end else if (running) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == rnd_w'(nr + 1))
                                running <= 1'b0;
                end
        end
end

always_ff @(posedge clk) begin
        if (en)
                state <= plaintext;
        else if (running) begin
                if (cnt == rnd_w'(1))
                        state <= state ^ key;                   // Initial key addition.
                else if (cnt == rnd_w'(nr + 1))
                        state <= ss ^ key;                      // Last round, no mix.
                else if (cnt != '0)
                        state <= mixed ^ key;
        end
end

endmodule

// ==== src/decipher.sv ====
`timescale 1ns/100ps

module decipher import aes_pkg::*; (
        input  logic             clk,
        input  logic             reset,
        input  logic             en,

        input  logic [0:blk_s-1] ciphertext,
        input  logic [0:key_s-1] round_key,
        output logic [rnd_w-1:0] round_no,

        output logic [0:blk_s-1] plaintext,
        output logic             en_o
);

logic             running;
logic [rnd_w-1:0] cnt;
logic [0:blk_s-1] state;
logic [0:blk_s-1] inv_ss;
logic [0:blk_s-1] keyed;
logic [0:blk_s-1] unmixed;

// InvShiftRows and InvSubBytes commute and run in one pass.
function automatic logic [0:blk_s-1] inv_shift_sub(input logic [0:blk_s-1] s);
        logic [0:blk_s-1] t;
        for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                        t[8*(4*c+r) +: 8] = inv_sbox(s[8*(4*((c-r+4)%4)+r) +: 8]);
                end
        end
        return t;
endfunction

function automatic logic [0:blk_s-1] inv_mix_cols(input logic [0:blk_s-1] s);
        logic [0:blk_s-1] t;
        for (int c = 0; c < 4; c++) begin
                t[32*c +: 32] = inv_mix_col(s[32*c +: 32]);
        end
        return t;
endfunction

assign inv_ss = inv_shift_sub(state);
assign keyed = inv_ss ^ round_key;
assign unmixed = inv_mix_cols(keyed);
assign round_no = (cnt > rnd_w'(nr)) ? '0 : rnd_w'(nr) - cnt;   // Keys in reverse order.
assign plaintext = state;

always_ff @(posedge clk) begin
        if (reset) begin
                running <= 1'b0;
                cnt <= '0;
                en_o <= 1'b0;
        end else begin
                en_o <= running && cnt == rnd_w'(nr + 1);
                if (en) begin
                        running <= 1'b1;
                        cnt <= '0;
                end else if (running) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == rnd_w'(nr + 1))
                                running <= 1'b0;
                end
        end
end

always_ff @(posedge clk) begin
        if (en)
                state <= ciphertext;
        else if (running) begin
                if (cnt == rnd_w'(1))
                        state <= state ^ round_key;             // Round key 10 first.
                else if (cnt == rnd_w'(nr + 1))
                        state <= keyed;
                else if (cnt != '0)
                        state <= unmixed;
        end
end

endmodule

// ==== src/aes_top.sv ====
`timescale 1ns/100ps

module aes_top import aes_pkg::*; (
        input  logic             clk,
        input  logic             reset,
        input  logic             en,

        input  logic [cmd_w-1:0] aes_cmd,
        input  logic [0:key_s-1] aes_key,
        input  logic [0:blk_s-1] aes_in_blk,

        output logic [0:blk_s-1] aes_out_blk,
        output logic             aes_op_in_progress,
        output logic             en_o
);

logic             en_key, en_enc, en_dec;
logic             en_o_key, en_o_enc, en_o_dec;
logic             enc_sel;
logic             w_e;
logic [rnd_w-1:0] addr;
logic [rnd_w-1:0] key_round_no, enc_round_no, dec_round_no;
logic [0:key_s-1] round_key_w, round_key_r;
logic [0:blk_s-1] enc_blk, dec_blk;

assign en_key = en && aes_cmd == cmd_set_key;
assign en_enc = en && aes_cmd == cmd_encrypt;
assign en_dec = en && aes_cmd == cmd_decrypt;

round_key key_gen (
        .clk(clk), .reset(reset), .en(en_key),
        .key(aes_key),
        .round_key(round_key_w), .round_no(key_round_no), .w_e(w_e),
        .en_o(en_o_key)
);

// Key writes win over engine reads.
assign addr = w_e ? key_round_no : (enc_sel ? enc_round_no : dec_round_no);

block_ram #(
        .addr_width(rnd_w),
        .data_width(key_s)
) key_ram (
        .clk(clk),
        .addr(addr), .i_data(round_key_w), .w_e(w_e),
        .o_data(round_key_r)
);

cipher enc (
        .clk(clk), .reset(reset), .en(en_enc),
        .plaintext(aes_in_blk), .key(round_key_r), .round_no(enc_round_no),
        .ciphertext(enc_blk), .en_o(en_o_enc)
);

decipher dec (
        .clk(clk), .reset(reset), .en(en_dec),
        .ciphertext(aes_in_blk), .round_key(round_key_r), .round_no(dec_round_no),
        .plaintext(dec_blk), .en_o(en_o_dec)
);

assign aes_out_blk = en_o_enc ? enc_blk : (en_o_dec ? dec_blk : '0);
assign en_o = en_o_key | en_o_enc | en_o_dec;

// A no-op strobe leaves busy low.
always_ff @(posedge clk) begin
        if (reset) begin
                enc_sel <= 1'b0;
                aes_op_in_progress <= 1'b0;
        end else begin
                if (en_enc)
                        enc_sel <= 1'b1;
                else if (en_dec)
                        enc_sel <= 1'b0;
                if (en_key || en_enc || en_dec)
                        aes_op_in_progress <= 1'b1;
                else if (en_o)
                        aes_op_in_progress <= 1'b0;
        end
end

endmodule

// ==== bench/aes_top_sva.sv ====
`timescale 1ns/100ps

module aes_top_sva (
        input logic             clk,
        input logic             reset,
        input logic             en,
        input logic             aes_op_in_progress,
        input logic             en_o
);

int fail_cnt = 0;

// One operation at a time.
no_cmd_while_busy: assert property (@(posedge clk) disable iff (reset)
        en |-> !aes_op_in_progress)
        else begin
                $error("en strobed while an operation is in progress");
                fail_cnt++;
        end

busy_at_done: assert property (@(posedge clk) disable iff (reset)
        en_o |-> aes_op_in_progress)
        else begin
                $error("en_o pulsed with no operation in progress");
                fail_cnt++;
        end

idle_after_done: assert property (@(posedge clk) disable iff (reset)
        en_o |=> !aes_op_in_progress)
        else begin
                $error("aes_op_in_progress still high after en_o");
                fail_cnt++;
        end

endmodule

bind aes_top aes_top_sva i_sva (.*);

// ==== bench/aes_top_tb.sv ====
`timescale 1ns/100ps

module aes_top_tb import aes_pkg::*; ();

localparam int n_ops = 25;                      // Commands issued over all tests.
localparam int cycle_limit = 20 * 14 * n_ops;

logic             clk;
logic             reset;
logic             en;
logic [cmd_w-1:0] aes_cmd;
logic [0:key_s-1] aes_key;
logic [0:blk_s-1] aes_in_blk;
logic [0:blk_s-1] aes_out_blk;
logic             aes_op_in_progress;
logic             en_o;

int checks = 0;
int errors = 0;
int sva_fails = 0;
int cycles = 0;
int seed = 32'h9a59cc1e;

aes_top i_aes_top (
        .clk(clk), .reset(reset), .en(en),
        .aes_cmd(aes_cmd), .aes_key(aes_key), .aes_in_blk(aes_in_blk),
        .aes_out_blk(aes_out_blk), .aes_op_in_progress(aes_op_in_progress), .en_o(en_o)
);

always #50 clk = ~clk;

task automatic check_blk(input string name, input logic [0:blk_s-1] exp,
                input logic [0:blk_s-1] act);
        checks++;
        if (act !== exp) begin
                errors++;
                $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
                errors++;
                $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
endtask

task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
                errors++;
                $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
endtask

// Follows one command up to the cycle after its completion pulse.
task automatic run_cmd(input string name, input logic [cmd_w-1:0] cmd,
                input logic [0:blk_s-1] blk, input int latency,
                output logic [0:blk_s-1] result);
        int n;
        n = 0;
        aes_cmd = cmd;
        aes_in_blk = blk;
        en = 1'b1;
        @(posedge clk);
        #1;
        en = 1'b0;
        while (!en_o && n < 20) begin
                check_bit({name, " busy"}, 1'b1, aes_op_in_progress);
                if (cmd == cmd_set_key)
                        check_blk({name, " out"}, '0, aes_out_blk);
                @(posedge clk);
                #1;
                n++;
        end
        if (!en_o) begin
                errors++;
                $display("%s: no completion pulse within 20 cycles", name);
        end
        check_count({name, " latency"}, latency, n);
        check_bit({name, " busy at done"}, 1'b1, aes_op_in_progress);
        result = aes_out_blk;
        @(posedge clk);
        #1;
        check_bit({name, " busy after done"}, 1'b0, aes_op_in_progress);
endtask

task automatic set_key(input string name, input logic [0:key_s-1] key);
        logic [0:blk_s-1] res;
        aes_key = key;
        run_cmd(name, cmd_set_key, '0, 11, res);
        check_blk({name, " out"}, '0, res);             // No block for key setup.
endtask

task automatic encrypt(input string name, input logic [0:blk_s-1] blk,
                output logic [0:blk_s-1] res);
        run_cmd(name, cmd_encrypt, blk, 12, res);
endtask

task automatic decrypt(input string name, input logic [0:blk_s-1] blk,
                output logic [0:blk_s-1] res);
        run_cmd(name, cmd_decrypt, blk, 12, res);
endtask

task automatic fips_vector();
        logic [0:blk_s-1] res;
        set_key("fips key", 128'h000102030405060708090a0b0c0d0e0f);
        encrypt("fips encrypt", 128'h00112233445566778899aabbccddeeff, res);
        check_blk("fips encrypt", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, res);
        decrypt("fips decrypt", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, res);
        check_blk("fips decrypt", 128'h00112233445566778899aabbccddeeff, res);
endtask

task automatic second_key();
        logic [0:blk_s-1] res;
        set_key("second key", 128'h2b7e151628aed2a6abf7158809cf4f3c);
        encrypt("second encrypt", 128'h3243f6a8885a308d313198a2e0370734, res);
        check_blk("second encrypt", 128'h3925841d02dc09fbdc118597196a0b32, res);
endtask

task automatic random_round_trip();
        logic [0:blk_s-1] blk;
        logic [0:blk_s-1] ct;
        logic [0:blk_s-1] pt;
        for (int i = 0; i < 8; i++) begin
                blk = {$random(seed), $random(seed), $random(seed), $random(seed)};
                encrypt($sformatf("random %0d encrypt", i), blk, ct);
                decrypt($sformatf("random %0d decrypt", i), ct, pt);
                check_blk($sformatf("random %0d round trip", i), blk, pt);
        end
endtask

// Latency and busy are checked inside every command.
task automatic timing_busy();
        logic [0:blk_s-1] res;
        set_key("timing key", 128'h2b7e151628aed2a6abf7158809cf4f3c);
        decrypt("timing decrypt", 128'h3925841d02dc09fbdc118597196a0b32, res);
        check_blk("timing decrypt", 128'h3243f6a8885a308d313198a2e0370734, res);
endtask

task automatic nop_test();
        logic [0:blk_s-1] res;
        aes_cmd = cmd_w'(3);
        en = 1'b1;
        @(posedge clk);
        #1;
        en = 1'b0;
        repeat (20) begin
                check_bit("no-op en_o", 1'b0, en_o);
                check_bit("no-op busy", 1'b0, aes_op_in_progress);
                @(posedge clk);
                #1;
        end
        encrypt("no-op key kept", 128'h3243f6a8885a308d313198a2e0370734, res);
        check_blk("no-op key kept", 128'h3925841d02dc09fbdc118597196a0b32, res);
endtask

initial begin
        clk = 1'b0;
        reset = 1'b1;
        en = 1'b0;
        aes_cmd = '0;
        aes_key = '0;
        aes_in_blk = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        fips_vector();
        second_key();
        random_round_trip();
        timing_busy();
        nop_test();
        sva_fails = i_aes_top.i_sva.fail_cnt;
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0)
                $display("test passed");
        else
                $display("test failed");
        $finish;
end

initial begin
        while (cycles < cycle_limit) begin
                @(posedge clk);
                cycles++;
        end
        $display("Timeout, the tests did not finish within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
end

endmodule

// ==== sources.f ====
src/aes_pkg.sv
src/round_key.sv
src/block_ram.sv
src/cipher.sv
src/decipher.sv
src/aes_top.sv
bench/aes_top_sva.sv
bench/aes_top_tb.sv

// ==== Makefile ====
TOP = aes_top_tb

.PHONY: run build lint clean

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^test passed$$" sim.log

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
